// File: hdl/deparser_settings.svh
`ifndef DEPARSER_SETTINGS_SVH
`define DEPARSER_SETTINGS_SVH

// beat and vector widths
`define DATA_W 512
`define KEEP_W 64
`define USER_W 128
`define PHV_W 1124

// action table
`define N_ACT 10
`define ACT_W 16
`define TBL_DEPTH 16
`define TBL_ADDR_W 4
`define ENTRY_W (`N_ACT * `ACT_W)

// container regions in the PHV, eight of each size
`define C2_BASE 356
`define C4_BASE 484
`define C6_BASE 740
`define CONT_W 48

`define VLAN_POS 129
`define VLAN_W 12

// control beat fields
`define CTL_MOD_POS 368
`define CTL_IDX_POS 384
`define ENTRY_POS 100
`define DEPARSER_ID 3'b101

// action word layout
`define ACT_VLD_BIT 0
`define ACT_IDX_LSB 1
`define ACT_SIZE_LSB 4
`define ACT_OFF_LSB 6
`define ACT_OFF_W 7

`endif

// File: hdl/deparser_pkg.sv
`default_nettype none

`include "deparser_settings.svh"

package deparser_pkg;

	typedef logic [`DATA_W-1:0] data_t;
	typedef logic [`KEEP_W-1:0] keep_t;
	typedef logic [`USER_W-1:0] user_t;
	typedef logic [`PHV_W-1:0] phv_t;

	typedef logic [`ACT_W-1:0] action_t;
	typedef logic [`TBL_ADDR_W-1:0] tbl_addr_t;
	// action k at bit 144 - 16k
	typedef logic [`ENTRY_W-1:0] entry_t;

	typedef logic [1:0] size_t;
	typedef logic [`ACT_OFF_W-1:0] byte_off_t;
	typedef logic [`CONT_W-1:0] cont_t;

	typedef struct packed {
		data_t data;
		keep_t keep;
		user_t user;
		logic last;
	} beat_t;

	typedef struct packed {
		logic en;
		tbl_addr_t addr;
		entry_t entry;
	} tbl_wr_t;

	typedef struct packed {
		logic valid;
		size_t size;
		byte_off_t offset;
		cont_t value;
	} lane_t;

	typedef enum logic {
		ctl_idle,
		ctl_write
	} ctl_state_e;

	typedef enum logic [3:0] {
		st_idle,
		st_hdr_0,
		st_hdr_1,
		st_lookup,
		st_fetch,
		st_rewrite,
		st_flush_0,
		st_flush_1,
		st_stream
	} dep_state_e;

endpackage

`default_nettype wire

// File: hdl/deparse_ctrl_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "deparser_settings.svh"

module deparse_ctrl_loader (
	input wire clk,
	input wire aresetn,
	input wire deparser_pkg::data_t ctl_tdata,
	input wire ctl_tvalid,
	input wire ctl_tlast,
	output deparser_pkg::tbl_wr_t tbl_wr
);

	deparser_pkg::ctl_state_e state;
	deparser_pkg::tbl_addr_t next_idx;
	deparser_pkg::tbl_addr_t wr_addr;
	deparser_pkg::entry_t wr_entry;
	logic wr_en;
	logic id_match;

	// only the low three bits of the module id are compared
	assign id_match = ctl_tdata[`CTL_MOD_POS +: 3] == `DEPARSER_ID;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state <= deparser_pkg::ctl_idle;
			wr_en <= 1'b0;
			next_idx <= '0;
		end else begin
			wr_en <= 1'b0;
			case (state)
				deparser_pkg::ctl_idle: begin
					if (ctl_tvalid && id_match) begin
						next_idx <= ctl_tdata[`CTL_IDX_POS +: `TBL_ADDR_W];
						if (!ctl_tlast) begin
							state <= deparser_pkg::ctl_write;
						end
					end
				end
				default: begin
					if (ctl_tvalid) begin
						wr_en <= 1'b1;
						next_idx <= next_idx + 1'b1;
						if (ctl_tlast) begin
							state <= deparser_pkg::ctl_idle;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == deparser_pkg::ctl_write && ctl_tvalid) begin
			wr_addr <= next_idx;
			wr_entry <= ctl_tdata[`ENTRY_POS +: `ENTRY_W];
		end
	end

	assign tbl_wr = '{en: wr_en, addr: wr_addr, entry: wr_entry};

endmodule

`default_nettype wire

// File: hdl/deparse_action_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "deparser_settings.svh"

module deparse_action_table (
	input wire clk,
	input wire deparser_pkg::tbl_wr_t tbl_wr,
	input wire deparser_pkg::tbl_addr_t rd_addr,
	output deparser_pkg::entry_t rd_entry
);

	deparser_pkg::entry_t mem [`TBL_DEPTH];

	// single clock, write and registered read ports
	always_ff @(posedge clk) begin
		if (tbl_wr.en) begin
			mem[tbl_wr.addr] <= tbl_wr.entry;
		end
		rd_entry <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: hdl/phv_container_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "deparser_settings.svh"

module phv_container_fetch (
	input wire clk,
	input wire aresetn,
	input wire fetch,
	input wire deparser_pkg::phv_t phv,
	input wire deparser_pkg::entry_t entry,
	output deparser_pkg::lane_t lanes [`N_ACT],
	output logic done
);

	for (genvar k = 0; k < `N_ACT; k++) begin : g_lane
		deparser_pkg::action_t act;
		deparser_pkg::size_t size;
		logic [2:0] idx;
		deparser_pkg::cont_t cont;

		// action 0 sits highest in the entry
		assign act = entry[(`N_ACT - 1 - k) * `ACT_W +: `ACT_W];
		assign size = act[`ACT_SIZE_LSB +: 2];
		assign idx = act[`ACT_IDX_LSB +: 3];

		always_comb begin
			case (size)
				2'b01: cont = `CONT_W'(phv[`C2_BASE + 16 * idx +: 16]);
				2'b10: cont = `CONT_W'(phv[`C4_BASE + 32 * idx +: 32]);
				2'b11: cont = phv[`C6_BASE + 48 * idx +: 48];
				default: cont = '0;
			endcase
		end

		always_ff @(posedge clk) begin
			if (fetch) begin
				lanes[k].valid <= act[`ACT_VLD_BIT] && (size != 2'b00);
				lanes[k].size <= size;
				lanes[k].offset <= act[`ACT_OFF_LSB +: `ACT_OFF_W];
				lanes[k].value <= cont;
			end
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			done <= 1'b0;
		end else begin
			done <= fetch;
		end
	end

endmodule

`default_nettype wire

// File: hdl/deparse_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "deparser_settings.svh"

module deparse_fsm (
	input wire clk,
	input wire aresetn,
	input wire deparser_pkg::beat_t pkt_beat,
	input wire pkt_empty,
	output logic pkt_rd_en,
	input wire deparser_pkg::phv_t phv_in,
	input wire phv_empty,
	output logic phv_rd_en,
	output deparser_pkg::tbl_addr_t tbl_addr,
	output logic fetch,
	output deparser_pkg::phv_t phv_held,
	input wire deparser_pkg::lane_t lanes [`N_ACT],
	input wire done,
	output deparser_pkg::beat_t out_beat,
	output logic out_valid,
	input wire out_ready
);

	deparser_pkg::dep_state_e state;
	deparser_pkg::dep_state_e state_nxt;
	deparser_pkg::beat_t hdr_beat [2];
	logic [2*`DATA_W-1:0] merged;
	logic [`VLAN_W-1:0] vlan_id;
	logic start;
	logic in_hdr;

	assign start = state == deparser_pkg::st_idle && !pkt_empty && !phv_empty;
	assign in_hdr = state == deparser_pkg::st_hdr_0 || state == deparser_pkg::st_hdr_1;

	assign phv_rd_en = start;
	assign pkt_rd_en = start || (in_hdr && !pkt_empty) ||
		(state == deparser_pkg::st_stream && !pkt_empty && out_ready);

	// table index is vlan id bits 7:4
	assign vlan_id = phv_held[`VLAN_POS +: `VLAN_W];
	assign tbl_addr = vlan_id[7:4];
	assign fetch = state == deparser_pkg::st_fetch;

	always_comb begin
		state_nxt = state;
		case (state)
			deparser_pkg::st_idle:
				if (start) begin
					state_nxt = pkt_beat.last ? deparser_pkg::st_lookup : deparser_pkg::st_hdr_0;
				end
			// hdr_1 marks a beat 1 that arrived late
			deparser_pkg::st_hdr_0, deparser_pkg::st_hdr_1:
				state_nxt = pkt_empty ? deparser_pkg::st_hdr_1 : deparser_pkg::st_lookup;
			deparser_pkg::st_lookup: state_nxt = deparser_pkg::st_fetch;
			deparser_pkg::st_fetch: state_nxt = deparser_pkg::st_rewrite;
			deparser_pkg::st_rewrite:
				if (done) begin
					state_nxt = deparser_pkg::st_flush_0;
				end
			deparser_pkg::st_flush_0:
				if (out_ready) begin
					state_nxt = hdr_beat[0].last ? deparser_pkg::st_idle : deparser_pkg::st_flush_1;
				end
			deparser_pkg::st_flush_1:
				if (out_ready) begin
					state_nxt = hdr_beat[1].last ? deparser_pkg::st_idle : deparser_pkg::st_stream;
				end
			deparser_pkg::st_stream:
				if (pkt_rd_en && pkt_beat.last) begin
					state_nxt = deparser_pkg::st_idle;
				end
			default: state_nxt = deparser_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state <= deparser_pkg::st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// lanes in order, so the highest lane wins on overlap
	always_comb begin
		int nbytes;
		int pos;
		merged = {hdr_beat[1].data, hdr_beat[0].data};
		for (int k = 0; k < `N_ACT; k++) begin
			nbytes = 2 * int'(lanes[k].size);
			for (int b = 0; b < `CONT_W / 8; b++) begin
				pos = int'(lanes[k].offset) + b;
				// bytes past the second beat fall off
				if (lanes[k].valid && b < nbytes && pos < 2 * `DATA_W / 8) begin
					merged[pos * 8 +: 8] = lanes[k].value[b * 8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			phv_held <= phv_in;
			hdr_beat[0] <= pkt_beat;
		end else if (in_hdr && pkt_rd_en) begin
			hdr_beat[1] <= pkt_beat;
		end else if (state == deparser_pkg::st_rewrite && done) begin
			hdr_beat[0].data <= merged[0 +: `DATA_W];
			hdr_beat[1].data <= merged[`DATA_W +: `DATA_W];
		end
	end

	always_comb begin
		out_beat = pkt_beat;
		out_valid = 1'b0;
		case (state)
			deparser_pkg::st_flush_0: begin
				out_beat = hdr_beat[0];
				out_valid = 1'b1;
			end
			deparser_pkg::st_flush_1: begin
				out_beat = hdr_beat[1];
				out_valid = 1'b1;
			end
			// straight from the fifo, held until it drains
			deparser_pkg::st_stream: out_valid = !pkt_empty;
			default: out_valid = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/deparser_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "deparser_settings.svh"

module deparser_top (
	input wire clk,
	input wire aresetn,

	input wire deparser_pkg::beat_t pkt_beat,
	input wire pkt_empty,
	output logic pkt_rd_en,

	input wire deparser_pkg::phv_t phv_in,
	input wire phv_empty,
	output logic phv_rd_en,

	output deparser_pkg::beat_t out_beat,
	output logic out_valid,
	input wire out_ready,

	input wire deparser_pkg::data_t ctl_tdata,
	input wire ctl_tvalid,
	input wire ctl_tlast
);

	deparser_pkg::tbl_wr_t tbl_wr;
	deparser_pkg::tbl_addr_t tbl_addr;
	deparser_pkg::entry_t rd_entry;
	deparser_pkg::phv_t phv_held;
	deparser_pkg::lane_t lanes [`N_ACT];
	logic fetch;
	logic done;

	deparse_ctrl_loader ctrl_loader_i (
		.clk (clk),
		.aresetn (aresetn),
		.ctl_tdata (ctl_tdata),
		.ctl_tvalid (ctl_tvalid),
		.ctl_tlast (ctl_tlast),
		.tbl_wr (tbl_wr)
	);

	deparse_action_table action_table_i (
		.clk (clk),
		.tbl_wr (tbl_wr),
		.rd_addr (tbl_addr),
		.rd_entry (rd_entry)
	);

	phv_container_fetch container_fetch_i (
		.clk (clk),
		.aresetn (aresetn),
		.fetch (fetch),
		.phv (phv_held),
		.entry (rd_entry),
		.lanes (lanes),
		.done (done)
	);

	deparse_fsm fsm_i (
		.clk (clk),
		.aresetn (aresetn),
		.pkt_beat (pkt_beat),
		.pkt_empty (pkt_empty),
		.pkt_rd_en (pkt_rd_en),
		.phv_in (phv_in),
		.phv_empty (phv_empty),
		.phv_rd_en (phv_rd_en),
		.tbl_addr (tbl_addr),
		.fetch (fetch),
		.phv_held (phv_held),
		.lanes (lanes),
		.done (done),
		.out_beat (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

`default_nettype wire

// File: dv/deparser_props.sv
`timescale 1ns/1ps
`default_nettype none

module deparser_props (
	input wire clk,
	input wire aresetn,
	input wire deparser_pkg::beat_t out_beat,
	input wire out_valid,
	input wire out_ready,
	input wire pkt_rd_en,
	input wire pkt_empty,
	input wire phv_rd_en,
	input wire phv_empty
);

	int fail_count = 0;

	// stalled beat must hold
	beat_stable: assert property (@(posedge clk) disable iff (!aresetn)
		out_valid && !out_ready |=> out_valid && $stable(out_beat))
	else begin
		fail_count++;
		$error("output beat changed while stalled");
	end

	pkt_pop_ok: assert property (@(posedge clk) disable iff (!aresetn)
		pkt_rd_en |-> !pkt_empty)
	else begin
		fail_count++;
		$error("packet FIFO read while empty");
	end

	phv_pop_ok: assert property (@(posedge clk) disable iff (!aresetn)
		phv_rd_en |-> !phv_empty)
	else begin
		fail_count++;
		$error("PHV FIFO read while empty");
	end

	reset_quiet: assert property (@(posedge clk) !aresetn |-> !out_valid)
	else begin
		fail_count++;
		$error("out_valid high during reset");
	end

endmodule

bind deparse_fsm deparser_props props_i (
	.clk (clk),
	.aresetn (aresetn),
	.out_beat (out_beat),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.pkt_rd_en (pkt_rd_en),
	.pkt_empty (pkt_empty),
	.phv_rd_en (phv_rd_en),
	.phv_empty (phv_empty)
);

`default_nettype wire

// File: dv/tb_deparser.sv
`timescale 1ns/1ps
`default_nettype none

`include "deparser_settings.svh"

module tb_deparser;

	localparam int max_cycles = 4000;

	logic clk = 1'b0;
	logic aresetn;
	deparser_pkg::beat_t pkt_beat;
	logic pkt_empty;
	logic pkt_rd_en;
	deparser_pkg::phv_t phv_in;
	logic phv_empty;
	logic phv_rd_en;
	deparser_pkg::beat_t out_beat;
	logic out_valid;
	logic out_ready;
	deparser_pkg::data_t ctl_tdata;
	logic ctl_tvalid;
	logic ctl_tlast;

	integer seed = 13706;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int out_count = 0;
	logic pkt_pop = 1'b0;
	logic phv_pop = 1'b0;

	deparser_pkg::beat_t pkt_q [$];
	deparser_pkg::phv_t phv_q [$];
	deparser_pkg::beat_t exp_q [$];

	// table contents as the testbench expects them
	logic [15:0] shadow [16][10];
	logic [15:0] stage [4][10];

	deparser_top deparser_top_i (
		.clk (clk),
		.aresetn (aresetn),
		.pkt_beat (pkt_beat),
		.pkt_empty (pkt_empty),
		.pkt_rd_en (pkt_rd_en),
		.phv_in (phv_in),
		.phv_empty (phv_empty),
		.phv_rd_en (phv_rd_en),
		.out_beat (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.ctl_tdata (ctl_tdata),
		.ctl_tvalid (ctl_tvalid),
		.ctl_tlast (ctl_tlast)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: the tests did not finish within %0d cycles", max_cycles);
			$display("Test failed");
			$finish;
		end
	end

	// FIFO models, first word fall through
	always @(negedge clk) begin
		if (pkt_pop) begin
			pkt_q.delete(0);
		end
		if (phv_pop) begin
			phv_q.delete(0);
		end
		pkt_empty = pkt_q.size() == 0;
		pkt_beat = pkt_empty ? '0 : pkt_q[0];
		phv_empty = phv_q.size() == 0;
		phv_in = phv_empty ? '0 : phv_q[0];
		out_ready = ($random(seed) % 4) != 0;
		#1;
		pkt_pop = pkt_rd_en && !pkt_empty;
		phv_pop = phv_rd_en && !phv_empty;
		if (out_valid && out_ready) begin
			checks++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("output beat at %0t while no packet was pending", $time);
			end else begin
				if (out_beat !== exp_q[0]) begin
					errors++;
					$display("ERROR %0t: output beat %0d differs, last %b expected %b",
						$time, out_count, out_beat.last, exp_q[0].last);
				end
				exp_q.delete(0);
			end
			out_count++;
		end
	end

	function automatic logic [15:0] act_word(input logic v, input logic [2:0] idx,
		input logic [1:0] size, input logic [6:0] off);
		return {3'b000, off, size, idx, v};
	endfunction

	function automatic deparser_pkg::data_t rand_data();
		deparser_pkg::data_t d;
		for (int i = 0; i < `DATA_W / 32; i++) begin
			d[i * 32 +: 32] = $random(seed);
		end
		return d;
	endfunction

	function automatic deparser_pkg::phv_t make_phv(input logic [3:0] addr);
		logic [1151:0] w;
		deparser_pkg::phv_t p;
		for (int i = 0; i < 36; i++) begin
			w[i * 32 +: 32] = $random(seed);
		end
		p = w[`PHV_W-1:0];
		p[`VLAN_POS + 4 +: 4] = addr;
		return p;
	endfunction

	// rewrite rule applied to the two buffered beats
	function automatic logic [1023:0] apply_actions(input logic [1023:0] d,
		input deparser_pkg::phv_t phv, input logic [3:0] addr);
		logic [15:0] a;
		logic [47:0] cont;
		int width;
		int base;
		int pos;
		for (int k = 0; k < `N_ACT; k++) begin
			a = shadow[addr][k];
			width = 16 * int'(a[5:4]);
			case (a[5:4])
				2'b01: base = `C2_BASE;
				2'b10: base = `C4_BASE;
				default: base = `C6_BASE;
			endcase
			if (a[0] && width != 0) begin
				cont = phv[base + width * int'(a[3:1]) +: 48];
				for (int b = 0; b < width / 8; b++) begin
					pos = int'(a[12:6]) + b;
					if (pos < 128) begin
						d[pos * 8 +: 8] = cont[b * 8 +: 8];
					end
				end
			end
		end
		return d;
	endfunction

	task automatic clear_stage();
		for (int e = 0; e < 4; e++) begin
			for (int k = 0; k < `N_ACT; k++) begin
				stage[e][k] = '0;
			end
		end
	endtask

	// header beat, then n entry beats with an idle gap after the first
	task automatic load_table(input logic [7:0] mod_id, input logic [3:0] idx, input int n);
		deparser_pkg::data_t d;
		logic [3:0] wa;
		wa = idx;
		@(negedge clk);
		d = rand_data();
		d[`CTL_MOD_POS +: 8] = mod_id;
		d[`CTL_IDX_POS +: 8] = {4'h0, idx};
		ctl_tdata = d;
		ctl_tvalid = 1'b1;
		ctl_tlast = 1'b0;
		for (int e = 0; e < n; e++) begin
			@(negedge clk);
			if (e == 1) begin
				ctl_tvalid = 1'b0;
				ctl_tdata = rand_data();
				@(negedge clk);
			end
			d = rand_data();
			d[`CTL_MOD_POS +: 8] = 8'h00;
			for (int k = 0; k < `N_ACT; k++) begin
				d[`ENTRY_POS + 16 * (9 - k) +: 16] = stage[e][k];
				if (mod_id[2:0] == `DEPARSER_ID) begin
					shadow[wa][k] = stage[e][k];
				end
			end
			wa = wa + 4'd1;
			ctl_tdata = d;
			ctl_tvalid = 1'b1;
			ctl_tlast = e == n - 1;
		end
		@(negedge clk);
		ctl_tvalid = 1'b0;
		ctl_tlast = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic send_packet(input logic [3:0] addr, input int nbeats);
		deparser_pkg::phv_t phv;
		deparser_pkg::beat_t beats [$];
		deparser_pkg::beat_t b;
		logic [1023:0] hdr_data;
		for (int i = 0; i < nbeats; i++) begin
			b.data = rand_data();
			b.keep = {$random(seed), $random(seed)};
			b.user = {$random(seed), $random(seed), $random(seed), $random(seed)};
			b.last = i == nbeats - 1;
			beats.push_back(b);
		end
		phv = make_phv(addr);
		hdr_data = {(nbeats > 1) ? beats[1].data : '0, beats[0].data};
		hdr_data = apply_actions(hdr_data, phv, addr);
		@(posedge clk);
		phv_q.push_back(phv);
		for (int i = 0; i < nbeats; i++) begin
			pkt_q.push_back(beats[i]);
			b = beats[i];
			if (i < 2) begin
				b.data = hdr_data[i * `DATA_W +: `DATA_W];
			end
			exp_q.push_back(b);
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || pkt_q.size() != 0 || phv_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
	endtask

	task automatic check_idle_after_reset();
		repeat (10) begin
			@(negedge clk);
			#1;
			checks++;
			if (out_valid || pkt_rd_en || phv_rd_en) begin
				errors++;
				$display("ERROR %0t: activity after reset with empty FIFOs", $time);
			end
		end
	endtask

	task automatic test_one_beat();
		clear_stage();
		stage[0][0] = act_word(1'b1, 3'd0, 2'b01, 7'd0);
		stage[0][1] = act_word(1'b1, 3'd3, 2'b10, 7'd20);
		// crosses into the dropped half
		stage[0][2] = act_word(1'b1, 3'd5, 2'b11, 7'd61);
		stage[0][3] = act_word(1'b1, 3'd7, 2'b11, 7'd100);
		load_table(8'hd5, 4'd2, 1);
		send_packet(4'd2, 1);
		wait_drain();
	endtask

	task automatic test_three_beat();
		clear_stage();
		stage[0][0] = act_word(1'b1, 3'd1, 2'b11, 7'd4);
		stage[0][4] = act_word(1'b1, 3'd2, 2'b10, 7'd62);
		stage[0][6] = act_word(1'b1, 3'd6, 2'b01, 7'd104);
		stage[0][9] = act_word(1'b1, 3'd4, 2'b11, 7'd125);
		stage[1][2] = act_word(1'b1, 3'd0, 2'b10, 7'd70);
		stage[1][5] = act_word(1'b1, 3'd7, 2'b01, 7'd3);
		load_table(8'h05, 4'd5, 2);
		send_packet(4'd5, 3);
		send_packet(4'd6, 2);
		wait_drain();
	endtask

	task automatic test_foreign_id();
		clear_stage();
		for (int k = 0; k < `N_ACT; k++) begin
			stage[0][k] = act_word(1'b1, 3'(k), 2'b11, 7'(k * 6));
		end
		load_table(8'h03, 4'd5, 1);
		send_packet(4'd5, 2);
		clear_stage();
		stage[0][0] = act_word(1'b0, 3'd1, 2'b11, 7'd0);
		stage[0][1] = act_word(1'b1, 3'd2, 2'b00, 7'd8);
		stage[0][3] = act_word(1'b0, 3'd4, 2'b10, 7'd66);
		load_table(8'h05, 4'd9, 1);
		send_packet(4'd9, 2);
		wait_drain();
	endtask

	task automatic test_overlap();
		clear_stage();
		stage[0][1] = act_word(1'b1, 3'd2, 2'b11, 7'd20);
		stage[0][3] = act_word(1'b1, 3'd1, 2'b01, 7'd21);
		stage[0][7] = act_word(1'b1, 3'd3, 2'b10, 7'd22);
		stage[0][2] = act_word(1'b1, 3'd5, 2'b11, 7'd40);
		stage[0][8] = act_word(1'b1, 3'd0, 2'b11, 7'd40);
		load_table(8'h05, 4'd12, 1);
		send_packet(4'd12, 3);
		send_packet(4'd2, 1);
		send_packet(4'd5, 2);
		send_packet(4'd6, 1);
		wait_drain();
	endtask

	initial begin
		aresetn = 1'b0;
		pkt_beat = '0;
		pkt_empty = 1'b1;
		phv_in = '0;
		phv_empty = 1'b1;
		out_ready = 1'b0;
		ctl_tdata = '0;
		ctl_tvalid = 1'b0;
		ctl_tlast = 1'b0;
		for (int a = 0; a < 16; a++) begin
			for (int k = 0; k < `N_ACT; k++) begin
				shadow[a][k] = '0;
			end
		end
		repeat (8) @(negedge clk);
		aresetn = 1'b1;
		check_idle_after_reset();
		test_one_beat();
		test_three_beat();
		test_foreign_id();
		test_overlap();
		repeat (4) @(negedge clk);
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			deparser_top_i.fsm_i.props_i.fail_count);
		if (errors == 0 && deparser_top_i.fsm_i.props_i.fail_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hdl
hdl/deparser_pkg.sv
hdl/deparse_ctrl_loader.sv
hdl/deparse_action_table.sv
hdl/phv_container_fetch.sv
hdl/deparse_fsm.sv
hdl/deparser_top.sv
dv/deparser_props.sv
dv/tb_deparser.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_deparser -f tb.f -o tb_deparser_sim

out=$(./obj_dir/tb_deparser_sim +verilator+error+limit+100)
echo "$out"

if echo "$out" | grep -q "^Test passed$"; then
	exit 0
else
	exit 1
fi
